// ==== alert_pkg.sv ====
////////////////////////////////////////
// alert link shared types
////////////////////////////////////////

package alert_pkg;

  // one differential pair, a valid pair always has p != n
  typedef struct packed {
    logic p;
    logic n;
  } diff_pair_t;

  // idle encoding of a pair, it decodes to level low
  parameter diff_pair_t DiffIdle = '{p: 1'b0, n: 1'b1};

  // handshake states of the alert sender
  typedef enum logic [2:0] {
    Idle,
    AlertHsPhase1,
    AlertHsPhase2,
    PingHsPhase1,
    PingHsPhase2,
    Pause0,
    Pause1
  } sender_state_e;

endpackage

// ==== alert_if.sv ====
////////////////////////////////////////
// alert link pair bundle
////////////////////////////////////////

interface alert_if;

  import alert_pkg::*;

  // alert pair runs from the sender to the receiver
  diff_pair_t alert;

  // ping pair runs from the receiver to the sender, a level change asks for an answer
  diff_pair_t ping;

  // ack pair runs from the receiver to the sender and closes each handshake
  diff_pair_t ack;

  // the sender end drives the alert pair and listens to ping and ack
  modport sender (
    output alert,
    input  ping,
    input  ack
  );

  // the receiver end drives ping and ack and listens to the alert pair
  modport receiver (
    output ping,
    output ack,
    input  alert
  );

endinterface

// ==== diff_decode.sv ====
////////////////////////////////////////
// differential pair decoder
////////////////////////////////////////

module diff_decode #(
  parameter bit AsyncOn = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  alert_pkg::diff_pair_t diff_i,
  output logic                  level_o,
  output logic                  event_o,
  output logic                  sigint_o
);

  import alert_pkg::*;

  // pair as seen in the local clock domain
  diff_pair_t pair_s;
  logic       level_q;

  ////////////////////////////////////////
  // optional synchronizer stages
  ////////////////////////////////////////

  if (AsyncOn) begin : gen_sync_stages
    diff_pair_t sync1_q;
    diff_pair_t sync2_q;

    // both wires are sampled together so a skewed edge shows up as one bad cycle at most
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        sync1_q <= DiffIdle;
        sync2_q <= DiffIdle;
      end else begin
        sync1_q <= diff_i;
        sync2_q <= sync1_q;
      end
    end

    assign pair_s = sync2_q;
  end else begin : gen_no_sync
    // same clock on both ends, the pair is used directly
    assign pair_s = diff_i;
  end

  ////////////////////////////////////////
  // level and event decoding
  ////////////////////////////////////////

  // both wires equal is an encoding error
  assign sigint_o = (pair_s.p == pair_s.n);

  // a bad pair keeps the last valid level so no false event is seen
  assign level_o = sigint_o ? level_q : pair_s.p;

  // one cycle pulse on every change of the valid level
  assign event_o = level_o ^ level_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      level_q <= DiffIdle.p;
    end else begin
      level_q <= level_o;
    end
  end

endmodule

// ==== alert_sender.sv ====
////////////////////////////////////////
// alert sender
////////////////////////////////////////

module alert_sender #(
  parameter bit AsyncOn = 1'b0,
  parameter bit IsFatal = 1'b0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic alert_test_i,
  input  logic alert_req_i,
  output logic alert_ack_o,
  output logic alert_state_o,
  alert_if.sender bus
);

  import alert_pkg::*;

  logic ping_event, ping_sigint;
  logic ack_level, ack_sigint;

  // the ping decoder only needs the change of level
  diff_decode #(
    .AsyncOn(AsyncOn)
  ) u_decode_ping (
    .clk_i,
    .rst_ni,
    .diff_i  (bus.ping),
    .level_o (),
    .event_o (ping_event),
    .sigint_o(ping_sigint)
  );

  // the ack decoder only needs the level
  diff_decode #(
    .AsyncOn(AsyncOn)
  ) u_decode_ack (
    .clk_i,
    .rst_ni,
    .diff_i  (bus.ack),
    .level_o (ack_level),
    .event_o (),
    .sigint_o(ack_sigint)
  );

  ////////////////////////////////////////
  // request set registers
  ////////////////////////////////////////

  sender_state_e state_d, state_q;
  diff_pair_t    alert_d, alert_q;
  logic alert_set_d, alert_set_q, alert_clr;
  logic test_set_d, test_set_q;
  logic ping_set_d, ping_set_q, ping_clr;
  logic req_trigger, test_trigger, ping_trigger, alert_trigger;

  // requests arriving during a handshake are kept until the pause is over
  assign req_trigger = alert_req_i | alert_set_q;

  if (IsFatal) begin : gen_fatal
    // a fatal alert stays latched until reset and keeps the handshakes going
    assign alert_set_d = req_trigger;
  end else begin : gen_recov
    assign alert_set_d = alert_clr ? 1'b0 : req_trigger;
  end

  // test alerts are served once, whatever the fatal setting
  assign test_trigger  = alert_test_i | test_set_q;
  assign test_set_d    = alert_clr ? 1'b0 : test_trigger;
  assign alert_trigger = req_trigger | test_trigger;

  assign ping_trigger = ping_event | ping_set_q;
  assign ping_set_d   = ping_clr ? 1'b0 : ping_trigger;

  // only real alerts are acknowledged towards the peripheral
  assign alert_ack_o   = alert_clr & alert_set_q;
  assign alert_state_o = alert_set_q;
  assign bus.alert     = alert_q;

  ////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    alert_d   = DiffIdle;
    alert_clr = 1'b0;
    ping_clr  = 1'b0;

    unique case (state_q)
      // alerts win over pings when both are waiting
      Idle: begin
        if (alert_trigger || ping_trigger) begin
          state_d = alert_trigger ? AlertHsPhase1 : PingHsPhase1;
          alert_d = '{p: 1'b1, n: 1'b0};
        end
      end
      // hold the alert high until the receiver raises ack
      AlertHsPhase1: begin
        if (ack_level) begin
          state_d = AlertHsPhase2;
        end else begin
          alert_d = '{p: 1'b1, n: 1'b0};
        end
      end
      // the handshake is complete once ack drops again
      AlertHsPhase2: begin
        if (!ack_level) begin
          state_d   = Pause0;
          alert_clr = 1'b1;
        end
      end
      PingHsPhase1: begin
        if (ack_level) begin
          state_d = PingHsPhase2;
        end else begin
          alert_d = '{p: 1'b1, n: 1'b0};
        end
      end
      PingHsPhase2: begin
        if (!ack_level) begin
          state_d  = Pause0;
          ping_clr = 1'b1;
        end
      end
      // two quiet cycles separate back to back handshakes
      Pause0: state_d = Pause1;
      Pause1: state_d = Idle;
      default: state_d = Idle;
    endcase

    // a bad incoming pair is reported by an all-low output pair, pending alerts survive
    if (ping_sigint || ack_sigint) begin
      state_d   = Idle;
      alert_d   = '{p: 1'b0, n: 1'b0};
      alert_clr = 1'b0;
      ping_clr  = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      alert_q     <= DiffIdle;
      alert_set_q <= 1'b0;
      test_set_q  <= 1'b0;
      ping_set_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      alert_q     <= alert_d;
      alert_set_q <= alert_set_d;
      test_set_q  <= test_set_d;
      ping_set_q  <= ping_set_d;
    end
  end

endmodule

// ==== alert_receiver.sv ====
////////////////////////////////////////
// alert receiver
////////////////////////////////////////

module alert_receiver #(
  parameter bit AsyncOn = 1'b0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ping_req_i,
  output logic alert_o,
  output logic ping_ok_o,
  output logic integ_fail_o,
  alert_if.receiver bus
);

  import alert_pkg::*;

  // cycles in which a new error answer is held back, covering the round trip of the
  // previous answer through the sender and back, which is longer with synchronizers
  localparam logic [2:0] HoldOff = AsyncOn ? 3'd7 : 3'd3;

  logic alert_level, alert_event, alert_sigint;

  diff_decode #(
    .AsyncOn(AsyncOn)
  ) u_decode_alert (
    .clk_i,
    .rst_ni,
    .diff_i  (bus.alert),
    .level_o (alert_level),
    .event_o (alert_event),
    .sigint_o(alert_sigint)
  );

  diff_pair_t ack_d, ack_q;
  diff_pair_t ping_d, ping_q;
  logic ping_pend_d, ping_pend_q;
  logic [2:0] hold_d, hold_q;
  logic sigint_q;
  logic alert_rise, ping_send, integ_ack;

  ////////////////////////////////////////
  // handshake classification
  ////////////////////////////////////////

  // each handshake starts with a rise of the alert level
  assign alert_rise = alert_event & alert_level;

  // a rise while a ping waits is the ping answer, any other rise is an alert
  assign alert_o   = alert_rise & ~ping_pend_q;
  assign ping_ok_o = alert_rise & ping_pend_q;

  assign integ_fail_o = alert_sigint;

  // no new ping while one is open or while the alert pair is broken
  assign ping_send = ping_req_i & ~ping_pend_q & ~alert_sigint;

  // answer the start of a bad alert pair once, the echo of our own answer is ignored
  assign integ_ack = alert_sigint & ~sigint_q & (hold_q == 3'd0);

  assign bus.ack  = ack_q;
  assign bus.ping = ping_q;

  always_comb begin
    // ack mirrors the decoded alert level one cycle later
    ack_d  = '{p: alert_level, n: ~alert_level};
    hold_d = (hold_q != 3'd0) ? hold_q - 3'd1 : 3'd0;
    if (integ_ack) begin
      ack_d  = '{p: 1'b0, n: 1'b0};
      hold_d = HoldOff;
    end

    // a ping is a level change of the ping pair
    ping_d = ping_q;
    if (ping_send) begin
      ping_d = '{p: ~ping_q.p, n: ping_q.p};
    end

    ping_pend_d = ping_pend_q;
    if (ping_send) begin
      ping_pend_d = 1'b1;
    end
    if (ping_rise_done()) begin
      ping_pend_d = 1'b0;
    end
    // the sender drops its ping on a bad pair too, so both ends forget it
    if (alert_sigint) begin
      ping_pend_d = 1'b0;
    end
  end

  // the rise that closes an open ping
  function automatic logic ping_rise_done();
    return alert_rise & ping_pend_q;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q       <= DiffIdle;
      ping_q      <= DiffIdle;
      ping_pend_q <= 1'b0;
      hold_q      <= 3'd0;
      sigint_q    <= 1'b0;
    end else begin
      ack_q       <= ack_d;
      ping_q      <= ping_d;
      ping_pend_q <= ping_pend_d;
      hold_q      <= hold_d;
      sigint_q    <= alert_sigint;
    end
  end

endmodule

// ==== alert_link.sv ====
////////////////////////////////////////
// alert link top level
////////////////////////////////////////

module alert_link #(
  parameter bit AsyncOn = 1'b0,
  parameter bit IsFatal = 1'b0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic alert_req_i,
  input  logic alert_test_i,
  input  logic ping_req_i,
  // pairs coming back from the outside wires
  input  logic alert_p_i,
  input  logic alert_n_i,
  input  logic ping_p_i,
  input  logic ping_n_i,
  input  logic ack_p_i,
  input  logic ack_n_i,
  output logic alert_ack_o,
  output logic alert_state_o,
  output logic alert_o,
  output logic ping_ok_o,
  output logic integ_fail_o,
  // pairs leaving towards the outside wires
  output logic alert_p_o,
  output logic alert_n_o,
  output logic ping_p_o,
  output logic ping_n_o,
  output logic ack_p_o,
  output logic ack_n_o
);

  // each end has its own bundle so the wires between them stay outside
  alert_if snd_bus ();
  alert_if rcv_bus ();

  // sender side, ping and ack arrive from outside, alert leaves
  assign snd_bus.ping = '{p: ping_p_i, n: ping_n_i};
  assign snd_bus.ack  = '{p: ack_p_i, n: ack_n_i};
  assign alert_p_o    = snd_bus.alert.p;
  assign alert_n_o    = snd_bus.alert.n;

  // receiver side, alert arrives from outside, ping and ack leave
  assign rcv_bus.alert = '{p: alert_p_i, n: alert_n_i};
  assign ping_p_o      = rcv_bus.ping.p;
  assign ping_n_o      = rcv_bus.ping.n;
  assign ack_p_o       = rcv_bus.ack.p;
  assign ack_n_o       = rcv_bus.ack.n;

  alert_sender #(
    .AsyncOn(AsyncOn),
    .IsFatal(IsFatal)
  ) u_sender (
    .clk_i,
    .rst_ni,
    .alert_test_i,
    .alert_req_i,
    .alert_ack_o,
    .alert_state_o,
    .bus(snd_bus)
  );

  alert_receiver #(
    .AsyncOn(AsyncOn)
  ) u_receiver (
    .clk_i,
    .rst_ni,
    .ping_req_i,
    .alert_o,
    .ping_ok_o,
    .integ_fail_o,
    .bus(rcv_bus)
  );

endmodule

// ==== tb_alert_link_assert.sv ====
////////////////////////////////////////
// alert link protocol checks
////////////////////////////////////////

module tb_alert_link_assert (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     alert_p_i,
  input logic                     alert_n_i,
  input logic                     ping_p_i,
  input logic                     ping_n_i,
  input logic                     ack_p_i,
  input logic                     ack_n_i,
  input logic                     alert_ack_o,
  input logic                     alert_state_o,
  input logic                     alert_o,
  input logic                     ping_ok_o,
  input logic                     integ_fail_o,
  input logic                     alert_p_o,
  input logic                     alert_n_o,
  input logic                     ping_p_o,
  input logic                     ping_n_o,
  input logic                     ack_p_o,
  input logic                     ack_n_o,
  input alert_pkg::sender_state_e state_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import alert_pkg::*;

  // equal wires on the alert pair only follow a bad ping or ack pair one cycle earlier
  alert_differential: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (alert_p_o == alert_n_o) |-> $past((ack_p_i == ack_n_i) || (ping_p_i == ping_n_i)))
    else $error("alert pair lost its differential encoding");

  // the receiver mirrors the alert level, so ack cannot rise on a valid low alert
  ack_follows_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_p_o) |-> $past({alert_p_i, alert_n_i} != DiffIdle))
    else $error("ack rose while the alert pair was low");

  outputs_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({alert_ack_o, alert_state_o, alert_o, ping_ok_o, integ_fail_o,
                 alert_p_o, alert_n_o, ping_p_o, ping_n_o, ack_p_o, ack_n_o}))
    else $error("link output is unknown after reset");

  // the receiver keeps its ack pair idle for the whole sender pause
  pause_ack_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i inside {Pause0, Pause1}) |-> ({ack_p_i, ack_n_i} == DiffIdle))
    else $error("ack pair not idle during the sender pause");

endmodule

bind alert_link tb_alert_link_assert u_assert (
  .*,
  .state_i(u_sender.state_q)
);

// ==== tb_alert_link.sv ====
////////////////////////////////////////
// alert link testbench
////////////////////////////////////////

module tb_alert_link;

  timeunit 1ns;
  timeprecision 100ps;

  import alert_pkg::*;

  localparam int Timeout = 200;
  localparam int NumRows = 10;

  // what a table row does to the link
  typedef enum logic [2:0] {
    KindAlert,
    KindTest,
    KindPing,
    KindBadAlert,
    KindBadPing
  } kind_e;

  // stimulus first, then the pulse counts the row must produce
  typedef struct packed {
    kind_e      kind;
    logic [7:0] rep;
    logic [7:0] n_alert;
    logic [7:0] n_ack;
    logic [7:0] n_ping;
    logic       integ;
  } row_t;

  // an alert row with rep above one holds the request for that many handshakes
  localparam row_t Rows [NumRows] = '{
    '{KindAlert,    8'd1, 8'd1, 8'd1, 8'd0, 1'b0},
    '{KindTest,     8'd1, 8'd1, 8'd0, 8'd0, 1'b0},
    '{KindPing,     8'd1, 8'd0, 8'd0, 8'd1, 1'b0},
    '{KindAlert,    8'd3, 8'd3, 8'd3, 8'd0, 1'b0},
    '{KindBadAlert, 8'd4, 8'd0, 8'd0, 8'd0, 1'b1},
    '{KindAlert,    8'd1, 8'd1, 8'd1, 8'd0, 1'b0},
    '{KindBadPing,  8'd4, 8'd0, 8'd0, 8'd0, 1'b1},
    '{KindAlert,    8'd1, 8'd1, 8'd1, 8'd0, 1'b0},
    '{KindPing,     8'd2, 8'd0, 8'd0, 8'd2, 1'b0},
    '{KindTest,     8'd2, 8'd2, 8'd0, 8'd0, 1'b0}
  };

  logic clk_i = 1'b0;
  logic rst_ni, alert_req_i, alert_test_i, ping_req_i;
  logic alert_p_i, alert_n_i, ping_p_i, ping_n_i, ack_p_i, ack_n_i;
  logic alert_ack_o, alert_state_o, alert_o, ping_ok_o, integ_fail_o;
  logic alert_p_o, alert_n_o, ping_p_o, ping_n_o, ack_p_o, ack_n_o;
  logic alert_bad, ping_bad;
  int alert_cnt, ack_cnt, ping_cnt, integ_cnt, state_cnt;
  integer seed = 32'hc8c9d703;

  always #50 clk_i = ~clk_i;

  alert_link #(
    .AsyncOn(1'b0),
    .IsFatal(1'b0)
  ) alert_link_i (.*);

  ////////////////////////////////////////
  // wire model between the two ends
  ////////////////////////////////////////

  // a corrupted pair has both wires high and the ack pair is never touched
  assign alert_p_i = alert_bad ? 1'b1 : alert_p_o;
  assign alert_n_i = alert_bad ? 1'b1 : alert_n_o;
  assign ping_p_i  = ping_bad ? 1'b1 : ping_p_o;
  assign ping_n_i  = ping_bad ? 1'b1 : ping_n_o;
  assign ack_p_i   = ack_p_o;
  assign ack_n_i   = ack_n_o;

  // every output pulse lasts one cycle, so one sample per cycle counts it once
  always @(negedge clk_i) begin
    alert_cnt += int'(alert_o);
    ack_cnt   += int'(alert_ack_o);
    ping_cnt  += int'(ping_ok_o);
    integ_cnt += int'(integ_fail_o);
    state_cnt += int'(alert_state_o);
  end

  // inputs change and outputs are read 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp)
    else begin
      $display("MISMATCH at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("TIMEOUT at %0d ns: %s within %0d cycles", $time, what, Timeout);
    abort_run();
  endtask

  // wait until the monitor has seen the given totals, optionally with the alert state held high
  task automatic wait_for(input int a, input int k, input int p, input bit state_high);
    int cycles;
    cycles = 0;
    while (alert_cnt < a || ack_cnt < k || ping_cnt < p) begin
      if (state_high) begin
        check_value("alert_state_o", int'(alert_state_o), 1);
      end
      next_cycle();
      cycles++;
      if (cycles > Timeout) begin
        report_timeout("expected handshakes did not complete");
      end
    end
  endtask

  // the link is settled after four cycles with idle pairs, covering the sender pause
  task automatic wait_quiet();
    int cycles;
    int calm;
    cycles = 0;
    calm = 0;
    while (calm < 4) begin
      next_cycle();
      if ({alert_p_o, alert_n_o} == DiffIdle && {ack_p_o, ack_n_o} == DiffIdle &&
          !integ_fail_o && !alert_state_o) begin
        calm++;
      end else begin
        calm = 0;
      end
      cycles++;
      if (cycles > Timeout) begin
        report_timeout("link did not return to idle");
      end
    end
  endtask

  ////////////////////////////////////////
  // row application
  ////////////////////////////////////////

  task automatic apply_row(input row_t r);
    int base_a;
    int base_k;
    int base_p;
    int base_i;
    int base_s;
    base_a = alert_cnt;
    base_k = ack_cnt;
    base_p = ping_cnt;
    base_i = integ_cnt;
    base_s = state_cnt;
    case (r.kind)
      KindAlert: begin
        alert_req_i = 1'b1;
        if (r.rep == 8'd1) begin
          // a single pulse is kept by the sender in its set register
          next_cycle();
          alert_req_i = 1'b0;
          wait_for(base_a + 1, base_k + 1, base_p, 1'b1);
        end else begin
          // the held request is dropped in the pause after the last acknowledge
          wait_for(base_a + int'(r.rep), base_k + int'(r.rep), base_p, 1'b0);
          alert_req_i = 1'b0;
        end
        wait_quiet();
      end
      KindTest, KindPing: begin
        // one pulse per repeat and each handshake runs to idle before the next one
        for (int i = 1; i <= int'(r.rep); i++) begin
          if (r.kind == KindTest) begin
            alert_test_i = 1'b1;
          end else begin
            ping_req_i = 1'b1;
          end
          next_cycle();
          alert_test_i = 1'b0;
          ping_req_i   = 1'b0;
          if (r.kind == KindTest) begin
            wait_for(base_a + i, base_k, base_p, 1'b0);
          end else begin
            wait_for(base_a, base_k, base_p + i, 1'b0);
          end
          wait_quiet();
        end
      end
      default: begin
        alert_bad = (r.kind == KindBadAlert);
        ping_bad  = (r.kind == KindBadPing);
        for (int i = 0; i < int'(r.rep); i++) begin
          next_cycle();
          if (alert_bad) begin
            check_value("integ_fail_o", int'(integ_fail_o), 1);
          end else begin
            // the sender answers a bad ping pair with equal wires on its own pair
            check_value("alert_p_o == alert_n_o", int'(alert_p_o == alert_n_o), 1);
          end
        end
        alert_bad = 1'b0;
        ping_bad  = 1'b0;
        wait_quiet();
      end
    endcase
    check_value("alert_o pulses", alert_cnt - base_a, int'(r.n_alert));
    check_value("alert_ack_o pulses", ack_cnt - base_k, int'(r.n_ack));
    check_value("ping_ok_o pulses", ping_cnt - base_p, int'(r.n_ping));
    check_value("integ_fail_o seen", int'(integ_cnt != base_i), int'(r.integ));
    if (r.kind != KindAlert) begin
      check_value("alert_state_o high cycles", state_cnt - base_s, 0);
    end
    check_value("alert pair", int'({alert_p_o, alert_n_o}), int'(DiffIdle));
    check_value("ack pair", int'({ack_p_o, ack_n_o}), int'(DiffIdle));
  endtask

  initial begin
    int gap;
    rst_ni       = 1'b0;
    alert_req_i  = 1'b0;
    alert_test_i = 1'b0;
    ping_req_i   = 1'b0;
    alert_bad    = 1'b0;
    ping_bad     = 1'b0;
    repeat (4) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    next_cycle();

    // control outputs and pairs come out of reset quiet
    check_value("alert_ack_o", int'(alert_ack_o), 0);
    check_value("alert_state_o", int'(alert_state_o), 0);
    check_value("alert_o", int'(alert_o), 0);
    check_value("ping_ok_o", int'(ping_ok_o), 0);
    check_value("integ_fail_o", int'(integ_fail_o), 0);
    check_value("ping pair", int'({ping_p_o, ping_n_o}), int'(DiffIdle));

    for (int r = 0; r < NumRows; r++) begin
      apply_row(Rows[r]);
      gap = $random(seed) & 32'h3;
      repeat (gap) next_cycle();
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== vlog.f ====
alert_pkg.sv
alert_if.sv
diff_decode.sv
alert_sender.sv
alert_receiver.sv
alert_link.sv
tb_alert_link_assert.sv
tb_alert_link.sv

// ==== run.sh ====
#!/bin/sh
# build and run the alert link testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module tb_alert_link -f vlog.f -o sim_alert_link; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_alert_link
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished without errors"
exit 0
